/* verification/drp_txn_input.txt */
# op (W write, R read, P write and read together) byte_addr wdata resp rdata
# resp 0 is OKAY, 3 is DECERR; reads ignore wdata
W 00000014 ABCD1234 0 00000000
R 00000014 00000000 0 00001234
W 00000814 5555BEEF 0 00000000
W 00001014 0000CAFE 0 00000000
R 00000814 00000000 0 0000BEEF
R 00001014 00000000 0 0000CAFE
R 00000014 00000000 0 00001234
W 00001814 12345678 3 00000000
R 00001814 00000000 3 00000000
R 000007FC 00000000 0 00000000
W 000007FC FFFF0001 0 00000000
R 000007FC 00000000 0 00000001
W 00000FFC 8000A5A5 0 00000000
R 00000FFC 00000000 0 0000A5A5
R 000017FC 00000000 0 00000000
P 00000820 00007777 0 00007777
P 00001820 00004444 3 00000000
R 00000020 00000000 0 00000000
W 00001BFC 0000FFFF 3 00000000
R 00001BFC 00000000 3 00000000

/* src.f */
logic/drp_bridge_pkg.sv
logic/drp_req_if.sv
logic/drp_request_reg.sv
logic/drp_txn_fsm.sv
logic/drp_port_mux.sv
logic/drp_bridge.sv
verification/drp_bridge_properties.sv
verification/drp_bridge_tb.sv

/* Makefile */
VERILATOR ?= verilator
TOP       ?= drp_bridge_tb
FILELIST  ?= src.f
BUILD_DIR ?= obj_dir
VFLAGS    ?= --binary --timing --assert
PASS_MSG  ?= Finished with no errors

.PHONY: all build run lint clean

all: run

build:
	$(VERILATOR) $(VFLAGS) -f $(FILELIST) --top-module $(TOP) --Mdir $(BUILD_DIR)

run: build
	@out="$$(./$(BUILD_DIR)/V$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -qx "$(PASS_MSG)"

lint:
	$(VERILATOR) --lint-only --timing -f $(FILELIST) --top-module $(TOP)

clean:
	rm -rf $(BUILD_DIR)

/* verification/drp_bridge_tb.sv */
`timescale 1ns/10ps

module drp_bridge_tb;
  import drp_bridge_pkg::*;

  logic                      AXI_aclk;
  logic                      AXI_sreset;
  logic [AXI_ADDR_WIDTH-1:0] s_axi_awaddr;
  logic                      s_axi_awvalid;
  logic                      s_axi_awready;
  logic [AXI_DATA_WIDTH-1:0] s_axi_wdata;
  logic                      s_axi_wvalid;
  logic                      s_axi_wready;
  logic [1:0]                s_axi_bresp;
  logic                      s_axi_bvalid;
  logic                      s_axi_bready;
  logic [AXI_ADDR_WIDTH-1:0] s_axi_araddr;
  logic                      s_axi_arvalid;
  logic                      s_axi_arready;
  logic [AXI_DATA_WIDTH-1:0] s_axi_rdata;
  logic [1:0]                s_axi_rresp;
  logic                      s_axi_rvalid;
  logic                      s_axi_rready;
  logic [DRP_COUNT-1:0]      drp_en;
  logic [DRP_COUNT-1:0]      drp_we;
  drp_addr_t                 drp_addr;
  drp_data_t                 drp_di;
  drp_data_t [DRP_COUNT-1:0] drp_do;
  logic [DRP_COUNT-1:0]      drp_rdy;

  logic [DRP_DATA_WIDTH-1:0] mem [DRP_COUNT][512];  // DRP slave contents
  int                        rdy_cnt [DRP_COUNT];
  drp_addr_t                 lat_addr [DRP_COUNT];
  byte                       ops [$];
  logic [31:0]               addrs [$];
  logic [31:0]               datas [$];
  logic [1:0]                resps [$];
  logic [31:0]               rdatas [$];
  logic [DRP_COUNT-1:0]      exp_en_mask;
  drp_addr_t                 exp_drp_addr;
  logic                      in_write;
  logic                      loaded;
  int                        errors;
  int                        checks;

  drp_bridge DUT (.*);

  initial begin
    AXI_aclk = 1'b0;
    forever #20 AXI_aclk = ~AXI_aclk;
  end

  // Three DRP slaves answering 1 to 4 cycles after enable
  always @(negedge AXI_aclk) begin
    if (!AXI_sreset) begin
      for (int i = 0; i < DRP_COUNT; i++) begin
        drp_rdy[i] = 1'b0;
        if (rdy_cnt[i] != 0) begin
          rdy_cnt[i]--;
          if (rdy_cnt[i] == 0) begin
            drp_rdy[i] = 1'b1;
            drp_do[i]  = mem[i][lat_addr[i]];
          end
        end
        if (drp_en[i]) begin
          if (drp_we[i])
            mem[i][drp_addr] = drp_di;
          lat_addr[i] = drp_addr;
          rdy_cnt[i]  = $urandom_range(1, 4);
        end
      end
    end
  end

  always @(negedge AXI_aclk) begin
    if (!AXI_sreset && (drp_en & ~exp_en_mask) != '0) begin
      errors++;
      $display("DRP enable fired on a port that was not addressed (drp_en 0x%0h)", drp_en);
    end
    if (!AXI_sreset && drp_en != '0) begin
      check_value("drp_addr", 32'(drp_addr), 32'(exp_drp_addr));
      check_value("drp_we", 32'(drp_we), in_write ? 32'(exp_en_mask) : 32'h0);
    end
    if (in_write && s_axi_arready) begin
      errors++;
      $display("Read address accepted while a write was still in flight");
    end
  end

  initial begin
    wait (loaded);
    repeat (ops.size() * 40 + 8) @(posedge AXI_aclk);
    $display("Watchdog timeout, the transaction list did not complete");
    $display("Finished with errors");
    $finish;
  end

  function automatic logic [DRP_COUNT-1:0] port_mask(input logic [31:0] a);
    logic [1:0] sel;
    sel = a[12:11];
    if (int'(sel) < DRP_COUNT)
      return DRP_COUNT'(1) << sel;
    return '0;
  endfunction

  task automatic check_value(input string name, input logic [31:0] got, input logic [31:0] exp);
    checks++;
    if (got !== exp) begin
      errors++;
      $display("ERROR %s got 0x%08h expected 0x%08h", name, got, exp);
    end
  endtask

  task automatic check_quiet(input string phase);
    checks++;
    if (s_axi_awready || s_axi_wready || s_axi_bvalid || s_axi_arready || s_axi_rvalid ||
        drp_en != '0) begin
      errors++;
      $display("Handshake output or DRP enable active %s", phase);
    end
  endtask

  task automatic load_file();
    int    fd;
    string line;
    byte   op;
    logic [31:0] a, d, r;
    logic [1:0]  rsp;
    fd = $fopen("verification/drp_txn_input.txt", "r");
    if (fd == 0) begin
      errors++;
      $display("Could not open the transaction file");
      return;
    end
    while (!$feof(fd)) begin
      line = "";
      void'($fgets(line, fd));
      if (line.len() > 0 && line[0] != "#") begin
        if ($sscanf(line, "%c %h %h %h %h", op, a, d, rsp, r) == 5) begin
          ops.push_back(op);
          addrs.push_back(a);
          datas.push_back(d);
          resps.push_back(rsp);
          rdatas.push_back(r);
        end
      end
    end
    $fclose(fd);
  endtask

  // Called just after a falling edge
  task automatic write_txn(input logic [31:0] addr, input logic [31:0] data,
                           input logic [1:0] exp_resp);
    int stall;
    s_axi_awaddr  = addr;
    s_axi_awvalid = 1'b1;
    s_axi_wdata   = data;
    s_axi_wvalid  = 1'b1;
    in_write      = 1'b1;
    @(negedge AXI_aclk);
    while (!s_axi_awready) @(negedge AXI_aclk);
    @(negedge AXI_aclk);
    s_axi_awvalid = 1'b0;
    while (!s_axi_wready) @(negedge AXI_aclk);
    @(negedge AXI_aclk);
    s_axi_wvalid = 1'b0;
    while (!s_axi_bvalid) @(negedge AXI_aclk);
    check_value("s_axi_bresp", 32'(s_axi_bresp), 32'(exp_resp));
    stall = $urandom_range(0, 3);
    repeat (stall) begin
      @(negedge AXI_aclk);
      check_value("s_axi_bvalid", 32'(s_axi_bvalid), 32'h1);
      check_value("s_axi_bresp", 32'(s_axi_bresp), 32'(exp_resp));
    end
    s_axi_bready = 1'b1;
    @(negedge AXI_aclk);
    s_axi_bready = 1'b0;
    in_write     = 1'b0;
  endtask

  task automatic read_txn(input logic [31:0] addr, input logic [1:0] exp_resp,
                          input logic [31:0] exp_data, input logic raise);
    int stall;
    if (raise) begin
      s_axi_araddr  = addr;
      s_axi_arvalid = 1'b1;
    end
    @(negedge AXI_aclk);
    while (!s_axi_arready) @(negedge AXI_aclk);
    @(negedge AXI_aclk);
    s_axi_arvalid = 1'b0;
    while (!s_axi_rvalid) @(negedge AXI_aclk);
    check_value("s_axi_rresp", 32'(s_axi_rresp), 32'(exp_resp));
    check_value("s_axi_rdata", s_axi_rdata, exp_data);
    stall = $urandom_range(0, 3);
    repeat (stall) begin
      @(negedge AXI_aclk);
      check_value("s_axi_rvalid", 32'(s_axi_rvalid), 32'h1);
      check_value("s_axi_rresp", 32'(s_axi_rresp), 32'(exp_resp));
      check_value("s_axi_rdata", s_axi_rdata, exp_data);
    end
    s_axi_rready = 1'b1;
    @(negedge AXI_aclk);
    s_axi_rready = 1'b0;
  endtask

  initial begin
    void'($urandom(32'h8636acde));
    AXI_sreset    = 1'b1;
    s_axi_awaddr  = '0;
    s_axi_awvalid = 1'b0;
    s_axi_wdata   = '0;
    s_axi_wvalid  = 1'b0;
    s_axi_bready  = 1'b0;
    s_axi_araddr  = '0;
    s_axi_arvalid = 1'b0;
    s_axi_rready  = 1'b0;
    drp_do        = '0;
    drp_rdy       = '0;
    exp_en_mask   = '0;
    exp_drp_addr  = '0;
    in_write      = 1'b0;
    errors        = 0;
    checks        = 0;
    loaded        = 1'b0;
    for (int i = 0; i < DRP_COUNT; i++) begin
      rdy_cnt[i]  = 0;
      lat_addr[i] = '0;
      for (int j = 0; j < 512; j++)
        mem[i][j] = '0;
    end
    load_file();
    loaded = 1'b1;
    repeat (8) begin
      @(negedge AXI_aclk);
      check_quiet("during reset");
    end
    AXI_sreset = 1'b0;
    @(negedge AXI_aclk);
    check_quiet("after reset");
    for (int t = 0; t < ops.size(); t++) begin
      exp_en_mask  = port_mask(addrs[t]);
      exp_drp_addr = addrs[t][10:2];
      case (ops[t])
        "W": write_txn(addrs[t], datas[t], resps[t]);
        "R": read_txn(addrs[t], resps[t], rdatas[t], 1'b1);
        "P": begin  // Write and read raised in the same cycle
          s_axi_araddr  = addrs[t];
          s_axi_arvalid = 1'b1;
          write_txn(addrs[t], datas[t], resps[t]);
          read_txn(addrs[t], resps[t], rdatas[t], 1'b0);
        end
        default: begin
          errors++;
          $display("Unknown operation in transaction line %0d", t);
        end
      endcase
    end
    $display("Checks: %0d, errors: %0d", checks, errors);
    if (errors == 0)
      $display("Finished with no errors");
    else
      $display("Finished with errors");
    $finish;
  end

endmodule

/* verification/drp_bridge_properties.sv */
`timescale 1ns/10ps

module drp_bridge_properties (
  input logic                                      AXI_aclk,
  input logic                                      AXI_sreset,
  input logic [drp_bridge_pkg::DRP_COUNT-1:0]      drp_en,
  input logic [drp_bridge_pkg::DRP_COUNT-1:0]      drp_we,
  input logic                                      s_axi_bvalid,
  input logic                                      s_axi_bready,
  input logic [1:0]                                s_axi_bresp,
  input logic                                      s_axi_rvalid,
  input logic                                      s_axi_rready,
  input logic [1:0]                                s_axi_rresp,
  input logic [drp_bridge_pkg::AXI_DATA_WIDTH-1:0] s_axi_rdata,
  input drp_bridge_pkg::drp_sel_t                  port_sel
);
  import drp_bridge_pkg::*;

  assert property (@(posedge AXI_aclk) disable iff (AXI_sreset) $onehot0(drp_en))
    else $error("drp_en has more than one bit set");

  assert property (@(posedge AXI_aclk) disable iff (AXI_sreset) (drp_we & ~drp_en) == '0)
    else $error("drp_we without drp_en");

  assert property (@(posedge AXI_aclk) disable iff (AXI_sreset)
    s_axi_bvalid && !s_axi_bready |=> s_axi_bvalid && $stable(s_axi_bresp))
    else $error("Write response dropped before acceptance");

  assert property (@(posedge AXI_aclk) disable iff (AXI_sreset)
    s_axi_rvalid && !s_axi_rready |=> s_axi_rvalid && $stable(s_axi_rresp) && $stable(s_axi_rdata))
    else $error("Read response dropped before acceptance");

  assert property (@(posedge AXI_aclk) disable iff (AXI_sreset)
    drp_en != '0 |-> int'(port_sel) < DRP_COUNT)
    else $error("DRP enable on a bad select");

endmodule

bind drp_bridge drp_bridge_properties u_properties (.*, .port_sel(req.port_sel));

/* logic/drp_bridge.sv */
`timescale 1ns/10ps

module drp_bridge (
  input  logic                                          AXI_aclk,
  input  logic                                          AXI_sreset,
  input  logic [drp_bridge_pkg::AXI_ADDR_WIDTH-1:0]     s_axi_awaddr,
  input  logic                                          s_axi_awvalid,
  output logic                                          s_axi_awready,
  input  logic [drp_bridge_pkg::AXI_DATA_WIDTH-1:0]     s_axi_wdata,
  input  logic                                          s_axi_wvalid,
  output logic                                          s_axi_wready,
  output logic [1:0]                                    s_axi_bresp,
  output logic                                          s_axi_bvalid,
  input  logic                                          s_axi_bready,
  input  logic [drp_bridge_pkg::AXI_ADDR_WIDTH-1:0]     s_axi_araddr,
  input  logic                                          s_axi_arvalid,
  output logic                                          s_axi_arready,
  output logic [drp_bridge_pkg::AXI_DATA_WIDTH-1:0]     s_axi_rdata,
  output logic [1:0]                                    s_axi_rresp,
  output logic                                          s_axi_rvalid,
  input  logic                                          s_axi_rready,
  output logic [drp_bridge_pkg::DRP_COUNT-1:0]          drp_en,
  output logic [drp_bridge_pkg::DRP_COUNT-1:0]          drp_we,
  output drp_bridge_pkg::drp_addr_t                     drp_addr,
  output drp_bridge_pkg::drp_data_t                     drp_di,
  input  drp_bridge_pkg::drp_data_t [drp_bridge_pkg::DRP_COUNT-1:0] drp_do,
  input  logic [drp_bridge_pkg::DRP_COUNT-1:0]          drp_rdy
);
  import drp_bridge_pkg::*;

  logic capture_wr;
  logic capture_rd;
  logic capture_data;
  logic drp_start;
  logic drp_write;
  logic drp_done;

  drp_req_if req ();

  drp_request_reg u_request_reg (
    .AXI_aclk     (AXI_aclk),
    .AXI_sreset   (AXI_sreset),
    .s_axi_awaddr (s_axi_awaddr),
    .s_axi_araddr (s_axi_araddr),
    .s_axi_wdata  (s_axi_wdata),
    .capture_wr   (capture_wr),
    .capture_rd   (capture_rd),
    .capture_data (capture_data),
    .req          (req.reg_side)
  );

  drp_txn_fsm u_txn_fsm (
    .AXI_aclk      (AXI_aclk),
    .AXI_sreset    (AXI_sreset),
    .s_axi_awvalid (s_axi_awvalid),
    .s_axi_wvalid  (s_axi_wvalid),
    .s_axi_bready  (s_axi_bready),
    .s_axi_arvalid (s_axi_arvalid),
    .s_axi_rready  (s_axi_rready),
    .drp_done      (drp_done),
    .s_axi_awready (s_axi_awready),
    .s_axi_wready  (s_axi_wready),
    .s_axi_bvalid  (s_axi_bvalid),
    .s_axi_bresp   (s_axi_bresp),
    .s_axi_arready (s_axi_arready),
    .s_axi_rvalid  (s_axi_rvalid),
    .s_axi_rresp   (s_axi_rresp),
    .s_axi_rdata   (s_axi_rdata),
    .capture_wr    (capture_wr),
    .capture_rd    (capture_rd),
    .capture_data  (capture_data),
    .drp_start     (drp_start),
    .drp_write     (drp_write),
    .req           (req.seq_side)
  );

  drp_port_mux u_port_mux (
    .AXI_aclk   (AXI_aclk),
    .AXI_sreset (AXI_sreset),
    .drp_start  (drp_start),
    .drp_write  (drp_write),
    .drp_do     (drp_do),
    .drp_rdy    (drp_rdy),
    .drp_en     (drp_en),
    .drp_we     (drp_we),
    .drp_addr   (drp_addr),
    .drp_di     (drp_di),
    .drp_done   (drp_done),
    .req        (req.port_side)
  );

endmodule

/* logic/drp_port_mux.sv */
`timescale 1ns/10ps

module drp_port_mux (
  input  logic                                          AXI_aclk,
  input  logic                                          AXI_sreset,
  input  logic                                          drp_start,
  input  logic                                          drp_write,
  input  drp_bridge_pkg::drp_data_t [drp_bridge_pkg::DRP_COUNT-1:0] drp_do,
  input  logic [drp_bridge_pkg::DRP_COUNT-1:0]          drp_rdy,
  output logic [drp_bridge_pkg::DRP_COUNT-1:0]          drp_en,
  output logic [drp_bridge_pkg::DRP_COUNT-1:0]          drp_we,
  output drp_bridge_pkg::drp_addr_t                     drp_addr,
  output drp_bridge_pkg::drp_data_t                     drp_di,
  output logic                                          drp_done,
  drp_req_if.port_side                                  req
);
  import drp_bridge_pkg::*;

  logic [DRP_COUNT-1:0] port_hit;
  drp_data_t            sel_do;
  drp_data_t            rd_q;
  logic                 sel_rdy;
  logic                 pending;

  // One-hot decode, all zero for a select past the last port
  always_comb begin
    port_hit = '0;
    sel_do   = '0;
    for (int i = 0; i < DRP_COUNT; i++) begin
      if (int'(req.port_sel) == i) begin
        port_hit[i] = 1'b1;
        sel_do      = drp_do[i];
      end
    end
  end

  assign sel_rdy  = |(drp_rdy & port_hit);  // Other ports' ready ignored
  assign drp_done = pending & sel_rdy;

  always_ff @(posedge AXI_aclk or posedge AXI_sreset) begin
    if (AXI_sreset) begin
      drp_en  <= '0;
      drp_we  <= '0;
      pending <= 1'b0;
    end else begin
      drp_en <= drp_start ? port_hit : '0;
      drp_we <= (drp_start && drp_write) ? port_hit : '0;
      if (drp_start)
        pending <= 1'b1;
      else if (sel_rdy)
        pending <= 1'b0;
    end
  end

  always_ff @(posedge AXI_aclk) begin
    if (drp_done)
      rd_q <= sel_do;
  end

  assign req.rd_data = drp_done ? sel_do : rd_q;

  // Shared by every port, only the enables differ
  assign drp_addr = req.drp_addr;
  assign drp_di   = req.wr_data;

endmodule

/* logic/drp_txn_fsm.sv */
`timescale 1ns/10ps

module drp_txn_fsm (
  input  logic                                    AXI_aclk,
  input  logic                                    AXI_sreset,
  input  logic                                    s_axi_awvalid,
  input  logic                                    s_axi_wvalid,
  input  logic                                    s_axi_bready,
  input  logic                                    s_axi_arvalid,
  input  logic                                    s_axi_rready,
  input  logic                                    drp_done,
  output logic                                    s_axi_awready,
  output logic                                    s_axi_wready,
  output logic                                    s_axi_bvalid,
  output drp_bridge_pkg::axi_resp_t               s_axi_bresp,
  output logic                                    s_axi_arready,
  output logic                                    s_axi_rvalid,
  output drp_bridge_pkg::axi_resp_t               s_axi_rresp,
  output logic [drp_bridge_pkg::AXI_DATA_WIDTH-1:0] s_axi_rdata,
  output logic                                    capture_wr,
  output logic                                    capture_rd,
  output logic                                    capture_data,
  output logic                                    drp_start,
  output logic                                    drp_write,
  drp_req_if.seq_side                             req
);
  import drp_bridge_pkg::*;

  bridge_state_t state_q;
  bridge_state_t state_d;
  logic          wr_hs;
  logic          wr_entry;
  logic          rd_entry;
  axi_resp_t     resp_code;

  // Handshake outputs straight from the state register
  assign s_axi_awready = (state_q == ST_WR_ADDR);
  assign s_axi_wready  = (state_q == ST_WR_DATA);
  assign s_axi_bvalid  = (state_q == ST_WR_RESP);
  assign s_axi_arready = (state_q == ST_RD_ADDR);
  assign s_axi_rvalid  = (state_q == ST_RD_RESP);

  assign wr_hs        = s_axi_wvalid & s_axi_wready;
  assign capture_wr   = s_axi_awready & s_axi_awvalid;
  assign capture_rd   = s_axi_arready & s_axi_arvalid;
  assign capture_data = wr_hs;

  assign drp_write = (state_q == ST_WR_DATA);
  assign drp_start = (wr_hs | capture_rd) & ~req.bad_addr;  // No access on bad select
  assign resp_code = req.bad_addr ? RESP_DECERR : RESP_OKAY;

  always_comb begin
    state_d = state_q;
    case (state_q)
      ST_IDLE: begin
        if (s_axi_awvalid)
          state_d = ST_WR_ADDR;  // Write wins a tie
        else if (s_axi_arvalid)
          state_d = ST_RD_ADDR;
      end
      ST_WR_ADDR: state_d = ST_WR_DATA;
      ST_WR_DATA: begin
        if (s_axi_wvalid)
          state_d = req.bad_addr ? ST_WR_RESP : ST_WR_WAIT;
      end
      ST_WR_WAIT: if (drp_done) state_d = ST_WR_RESP;
      ST_WR_RESP: if (s_axi_bready) state_d = ST_IDLE;
      ST_RD_ADDR: state_d = req.bad_addr ? ST_RD_RESP : ST_RD_WAIT;
      ST_RD_WAIT: if (drp_done) state_d = ST_RD_RESP;
      ST_RD_RESP: if (s_axi_rready) state_d = ST_IDLE;
    endcase
  end

  assign wr_entry = (state_d == ST_WR_RESP) && (state_q != ST_WR_RESP);
  assign rd_entry = (state_d == ST_RD_RESP) && (state_q != ST_RD_RESP);

  always_ff @(posedge AXI_aclk or posedge AXI_sreset) begin
    if (AXI_sreset) begin
      state_q     <= ST_IDLE;
      s_axi_bresp <= RESP_OKAY;
      s_axi_rresp <= RESP_OKAY;
    end else begin
      state_q <= state_d;
      if (wr_entry)
        s_axi_bresp <= resp_code;
      if (rd_entry)
        s_axi_rresp <= resp_code;
    end
  end

  // Held stable through read back-pressure
  always_ff @(posedge AXI_aclk) begin
    if (rd_entry) begin
      if (req.bad_addr)
        s_axi_rdata <= '0;
      else
        s_axi_rdata <= {{(AXI_DATA_WIDTH-DRP_DATA_WIDTH){1'b0}}, req.rd_data};
    end
  end

endmodule

/* logic/drp_request_reg.sv */
`timescale 1ns/10ps

module drp_request_reg (
  input  logic                                    AXI_aclk,
  input  logic                                    AXI_sreset,
  input  logic [drp_bridge_pkg::AXI_ADDR_WIDTH-1:0] s_axi_awaddr,
  input  logic [drp_bridge_pkg::AXI_ADDR_WIDTH-1:0] s_axi_araddr,
  input  logic [drp_bridge_pkg::AXI_DATA_WIDTH-1:0] s_axi_wdata,
  input  logic                                    capture_wr,
  input  logic                                    capture_rd,
  input  logic                                    capture_data,
  drp_req_if.reg_side                             req
);
  import drp_bridge_pkg::*;

  logic [AXI_ADDR_WIDTH-1:0] addr_mux;
  logic                      capture;
  drp_sel_t                  sel_live;
  drp_sel_t                  sel_q;
  logic                      bad_live;
  logic                      bad_q;

  assign capture  = capture_wr | capture_rd;
  assign addr_mux = capture_wr ? s_axi_awaddr : s_axi_araddr;  // Write side has priority
  assign sel_live = addr_mux[SEL_LSB +: SEL_WIDTH];
  assign bad_live = (int'(sel_live) >= DRP_COUNT);

  always_ff @(posedge AXI_aclk or posedge AXI_sreset) begin
    if (AXI_sreset) begin
      sel_q <= '0;
      bad_q <= 1'b0;
    end else if (capture) begin
      sel_q <= sel_live;
      bad_q <= bad_live;
    end
  end

  always_ff @(posedge AXI_aclk) begin
    if (capture)
      req.drp_addr <= addr_mux[ADDR_LSB +: DRP_ADDR_WIDTH];
    if (capture_data)
      req.wr_data <= s_axi_wdata[DRP_DATA_WIDTH-1:0];  // Upper half dropped
  end

  // Decode is visible during the address handshake itself,
  // so a read can branch or strobe without an extra cycle
  assign req.port_sel = capture ? sel_live : sel_q;
  assign req.bad_addr = capture ? bad_live : bad_q;

endmodule

/* logic/drp_req_if.sv */
`timescale 1ns/10ps

interface drp_req_if;
  import drp_bridge_pkg::*;

  drp_addr_t drp_addr;
  drp_sel_t  port_sel;
  logic      bad_addr;   // Select at or above DRP_COUNT
  drp_data_t wr_data;
  drp_data_t rd_data;

  modport reg_side (
    output drp_addr, port_sel, bad_addr, wr_data,
    input  rd_data
  );

  modport seq_side (input bad_addr, rd_data);

  modport port_side (
    input  drp_addr, port_sel, wr_data,
    output rd_data
  );

endinterface

/* logic/drp_bridge_pkg.sv */
package drp_bridge_pkg;

  localparam int DRP_COUNT      = 3;
  localparam int DRP_ADDR_WIDTH = 9;
  localparam int DRP_DATA_WIDTH = 16;
  localparam int AXI_ADDR_WIDTH = 32;
  localparam int AXI_DATA_WIDTH = 32;
  localparam int SEL_WIDTH      = 2;

  // Byte address fields
  localparam int ADDR_LSB = 2;   // DRP address in bits 10:2
  localparam int SEL_LSB  = 11;  // Port select in bits 12:11

  typedef logic [DRP_ADDR_WIDTH-1:0] drp_addr_t;
  typedef logic [DRP_DATA_WIDTH-1:0] drp_data_t;
  typedef logic [SEL_WIDTH-1:0]      drp_sel_t;

  typedef enum logic [1:0] {
    RESP_OKAY   = 2'd0,
    RESP_DECERR = 2'd3
  } axi_resp_t;

  typedef enum logic [2:0] {
    ST_IDLE,
    ST_WR_ADDR,
    ST_WR_DATA,
    ST_WR_WAIT,
    ST_WR_RESP,
    ST_RD_ADDR,
    ST_RD_WAIT,
    ST_RD_RESP
  } bridge_state_t;

endpackage
